// ==== src/conv_pkg.sv ====
package conv_pkg;

    // Data path widths
    localparam int ACT_W    = 16;
    localparam int WEIGHT_W = 8;
    localparam int ACC_W    = 32;

    // Input channels addressed by the activation tag
    localparam int NUM_IN_CHANS = 16;
    localparam int CHAN_W       = 4;

    // Output maps, one accumulator each
    localparam int NUM_OUT_MAPS = 4;
    localparam int MAP_W        = 2;

    // Layer count and configured number of layers
    localparam int LAYER_W = 4;

    // Zero activations skipped in one layer
    localparam int COUNT_W = 16;

    typedef enum logic [1:0] {
        ST_WAIT_WEIGHTS = 2'd0,
        ST_COMPUTE      = 2'd1,
        ST_DRAIN        = 2'd2
    } seq_state_t;

endpackage

// ==== src/zero_skip_fetch.sv ====
`timescale 1ns/10ps

module zero_skip_fetch (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         accept_en,
    input  logic                         layer_start,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  logic [conv_pkg::ACT_W-1:0]   in_act,
    input  logic [conv_pkg::CHAN_W-1:0]  in_chan,
    input  logic                         in_last,
    output logic                         fetch_valid,
    output logic [conv_pkg::ACT_W-1:0]   fetch_act,
    output logic [conv_pkg::CHAN_W-1:0]  fetch_chan,
    output logic                         fetch_last,
    output logic [conv_pkg::COUNT_W-1:0] skipped_count
);

    logic accepted;
    logic keep;

    assign in_ready = accept_en;
    assign accepted = in_valid && in_ready;

    // The last item always goes through so the layer can close
    assign keep = (in_act != '0) || in_last;

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= accepted && keep;
        end
    end

    always_ff @(posedge clk) begin
        if (accepted && keep) begin
            fetch_act  <= in_act;
            fetch_chan <= in_chan;
            fetch_last <= in_last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || layer_start) begin
            skipped_count <= '0;
        end else if (accepted && !keep) begin
            skipped_count <= skipped_count + 1'b1;
        end
    end

endmodule

// ==== src/weight_bank.sv ====
`timescale 1ns/10ps

module weight_bank (
    input  logic                                                    clk,
    input  logic                                                    reset,
    input  logic                                                    w_wr_en,
    input  logic [conv_pkg::CHAN_W-1:0]                             w_chan,
    input  logic [conv_pkg::MAP_W-1:0]                              w_map,
    input  logic [conv_pkg::WEIGHT_W-1:0]                           w_data,
    input  logic [conv_pkg::CHAN_W-1:0]                             rd_chan,
    output logic [conv_pkg::NUM_OUT_MAPS-1:0][conv_pkg::WEIGHT_W-1:0] rd_weights
);

    // One row per input channel, one weight per output map
    logic [conv_pkg::NUM_OUT_MAPS-1:0][conv_pkg::WEIGHT_W-1:0] bank [conv_pkg::NUM_IN_CHANS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int c = 0; c < conv_pkg::NUM_IN_CHANS; c++) begin
                bank[c] <= '0;
            end
        end else if (w_wr_en) begin
            bank[w_chan][w_map] <= w_data;
        end
    end

    // Whole row at once so every map sees its weight in the same cycle
    assign rd_weights = bank[rd_chan];

endmodule

// ==== src/pointwise_mac.sv ====
`timescale 1ns/10ps

module pointwise_mac (
    input  logic                                                      clk,
    input  logic                                                      reset,
    input  logic                                                      layer_start,
    input  logic                                                      fetch_valid,
    input  logic [conv_pkg::ACT_W-1:0]                                fetch_act,
    input  logic                                                      fetch_last,
    input  logic [conv_pkg::NUM_OUT_MAPS-1:0][conv_pkg::WEIGHT_W-1:0] rd_weights,
    output logic [conv_pkg::NUM_OUT_MAPS-1:0][conv_pkg::ACC_W-1:0]    acc,
    output logic                                                      layer_computed
);

    logic signed [conv_pkg::ACT_W-1:0] act_s;
    logic signed [conv_pkg::ACC_W-1:0] prod [conv_pkg::NUM_OUT_MAPS];

    assign act_s = $signed(fetch_act);

    // Products are formed at accumulator width, sign extended
    always_comb begin
        for (int m = 0; m < conv_pkg::NUM_OUT_MAPS; m++) begin
            prod[m] = act_s * $signed(rd_weights[m]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset || layer_start) begin
            acc <= '0;
        end else if (fetch_valid) begin
            for (int m = 0; m < conv_pkg::NUM_OUT_MAPS; m++) begin
                acc[m] <= acc[m] + prod[m];
            end
        end
    end

    // High the cycle after the last item was added in
    always_ff @(posedge clk) begin
        if (reset) begin
            layer_computed <= 1'b0;
        end else begin
            layer_computed <= fetch_valid && fetch_last;
        end
    end

endmodule

// ==== src/relu_drain.sv ====
`timescale 1ns/10ps

module relu_drain (
    input  logic                                                   clk,
    input  logic                                                   reset,
    input  logic                                                   drain_start,
    input  logic [conv_pkg::NUM_OUT_MAPS-1:0][conv_pkg::ACC_W-1:0] acc,
    input  logic [conv_pkg::LAYER_W-1:0]                           layer_num,
    output logic                                                   out_valid,
    input  logic                                                   out_ready,
    output logic [conv_pkg::ACC_W-1:0]                             out_data,
    output logic [conv_pkg::MAP_W-1:0]                             out_map,
    output logic [conv_pkg::LAYER_W-1:0]                           out_layer,
    output logic                                                   drain_done
);

    logic [conv_pkg::MAP_W-1:0] map_idx;
    logic [conv_pkg::ACC_W-1:0] sel_acc;
    logic                       xfer;
    logic                       last_map;

    assign xfer     = out_valid && out_ready;
    assign last_map = (map_idx == conv_pkg::MAP_W'(conv_pkg::NUM_OUT_MAPS - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            map_idx   <= '0;
        end else if (drain_start) begin
            out_valid <= 1'b1;
            map_idx   <= '0;
        end else if (xfer) begin
            if (last_map) begin
                out_valid <= 1'b0;
            end else begin
                map_idx <= map_idx + 1'b1;
            end
        end
    end

    // Accumulators and layer number hold still until the drain is over
    assign sel_acc    = acc[map_idx];
    assign out_data   = sel_acc[conv_pkg::ACC_W-1] ? '0 : sel_acc;
    assign out_map    = map_idx;
    assign out_layer  = layer_num;
    assign drain_done = xfer && last_map;

endmodule

// ==== src/layer_counter.sv ====
`timescale 1ns/10ps

module layer_counter (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         count_clear,
    input  logic                         layer_step,
    input  logic [conv_pkg::LAYER_W-1:0] num_layers_cfg,
    output logic [conv_pkg::LAYER_W-1:0] layer_num,
    output logic                         last_layer
);

    logic [conv_pkg::LAYER_W-1:0] next_num;

    always_ff @(posedge clk) begin
        if (reset || count_clear) begin
            layer_num <= '0;
        end else if (layer_step) begin
            layer_num <= next_num;
        end
    end

    assign next_num = layer_num + 1'b1;

    // Layer now draining is the final one of the run
    assign last_layer = (next_num == num_layers_cfg);

endmodule

// ==== src/layer_sequencer.sv ====
`timescale 1ns/10ps

module layer_sequencer (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         loading,
    input  logic [conv_pkg::LAYER_W-1:0] num_layers,
    input  logic                         layer_computed,
    input  logic                         drain_done,
    input  logic                         last_layer,
    output logic                         need_weights,
    output logic                         accept_en,
    output logic                         layer_start,
    output logic                         drain_start,
    output logic                         layer_step,
    output logic                         count_clear,
    output logic [conv_pkg::LAYER_W-1:0] num_layers_cfg,
    output logic                         run_done
);

    conv_pkg::seq_state_t state;
    logic                 seen_loading;
    logic                 run_active;
    logic                 run_end;

    // Weights are complete once loading has gone high and dropped again
    assign layer_start = (state == conv_pkg::ST_WAIT_WEIGHTS) && seen_loading && !loading;
    assign count_clear = layer_start && !run_active;
    assign drain_start = (state == conv_pkg::ST_COMPUTE) && layer_computed;
    assign layer_step  = (state == conv_pkg::ST_DRAIN) && drain_done;
    assign run_end     = layer_step && last_layer;

    assign need_weights = (state == conv_pkg::ST_WAIT_WEIGHTS);
    assign accept_en    = (state == conv_pkg::ST_COMPUTE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= conv_pkg::ST_WAIT_WEIGHTS;
            seen_loading <= 1'b0;
            run_active   <= 1'b0;
            run_done     <= 1'b0;
        end else begin
            run_done <= run_end;
            case (state)
                conv_pkg::ST_WAIT_WEIGHTS: begin
                    if (loading) begin
                        seen_loading <= 1'b1;
                    end
                    if (layer_start) begin
                        seen_loading <= 1'b0;
                        run_active   <= 1'b1;
                        state        <= conv_pkg::ST_COMPUTE;
                    end
                end
                conv_pkg::ST_COMPUTE: begin
                    if (drain_start) begin
                        state <= conv_pkg::ST_DRAIN;
                    end
                end
                conv_pkg::ST_DRAIN: begin
                    if (layer_step) begin
                        state <= conv_pkg::ST_WAIT_WEIGHTS;
                    end
                    if (run_end) begin
                        run_active <= 1'b0;
                    end
                end
                default: state <= conv_pkg::ST_WAIT_WEIGHTS;
            endcase
        end
    end

    // Layer count for the run, zero means a single layer
    always_ff @(posedge clk) begin
        if (reset) begin
            num_layers_cfg <= conv_pkg::LAYER_W'(1);
        end else if (count_clear) begin
            num_layers_cfg <= (num_layers == '0) ? conv_pkg::LAYER_W'(1) : num_layers;
        end
    end

endmodule

// ==== src/conv_engine_top.sv ====
`timescale 1ns/10ps

module conv_engine_top (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            loading,
    input  logic [conv_pkg::LAYER_W-1:0]    num_layers,
    input  logic                            w_wr_en,
    input  logic [conv_pkg::CHAN_W-1:0]     w_chan,
    input  logic [conv_pkg::MAP_W-1:0]      w_map,
    input  logic [conv_pkg::WEIGHT_W-1:0]   w_data,
    input  logic                            in_valid,
    output logic                            in_ready,
    input  logic [conv_pkg::ACT_W-1:0]      in_act,
    input  logic [conv_pkg::CHAN_W-1:0]     in_chan,
    input  logic                            in_last,
    output logic                            out_valid,
    input  logic                            out_ready,
    output logic [conv_pkg::ACC_W-1:0]      out_data,
    output logic [conv_pkg::MAP_W-1:0]      out_map,
    output logic [conv_pkg::LAYER_W-1:0]    out_layer,
    output logic                            need_weights,
    output logic                            run_done,
    output logic [conv_pkg::COUNT_W-1:0]    skipped_count
);

    logic                                                      accept_en;
    logic                                                      layer_start;
    logic                                                      drain_start;
    logic                                                      drain_done;
    logic                                                      layer_step;
    logic                                                      count_clear;
    logic                                                      layer_computed;
    logic                                                      last_layer;
    logic [conv_pkg::LAYER_W-1:0]                              num_layers_cfg;
    logic [conv_pkg::LAYER_W-1:0]                              layer_num;
    logic                                                      fetch_valid;
    logic [conv_pkg::ACT_W-1:0]                                fetch_act;
    logic [conv_pkg::CHAN_W-1:0]                               fetch_chan;
    logic                                                      fetch_last;
    logic [conv_pkg::NUM_OUT_MAPS-1:0][conv_pkg::WEIGHT_W-1:0] rd_weights;
    logic [conv_pkg::NUM_OUT_MAPS-1:0][conv_pkg::ACC_W-1:0]    acc;

    zero_skip_fetch u_fetch (
        .clk           (clk),
        .reset         (reset),
        .accept_en     (accept_en),
        .layer_start   (layer_start),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_act        (in_act),
        .in_chan       (in_chan),
        .in_last       (in_last),
        .fetch_valid   (fetch_valid),
        .fetch_act     (fetch_act),
        .fetch_chan    (fetch_chan),
        .fetch_last    (fetch_last),
        .skipped_count (skipped_count)
    );

    weight_bank u_weights (
        .clk        (clk),
        .reset      (reset),
        .w_wr_en    (w_wr_en),
        .w_chan     (w_chan),
        .w_map      (w_map),
        .w_data     (w_data),
        .rd_chan    (fetch_chan),
        .rd_weights (rd_weights)
    );

    pointwise_mac u_mac (
        .clk            (clk),
        .reset          (reset),
        .layer_start    (layer_start),
        .fetch_valid    (fetch_valid),
        .fetch_act      (fetch_act),
        .fetch_last     (fetch_last),
        .rd_weights     (rd_weights),
        .acc            (acc),
        .layer_computed (layer_computed)
    );

    relu_drain u_drain (
        .clk         (clk),
        .reset       (reset),
        .drain_start (drain_start),
        .acc         (acc),
        .layer_num   (layer_num),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_data    (out_data),
        .out_map     (out_map),
        .out_layer   (out_layer),
        .drain_done  (drain_done)
    );

    layer_counter u_count (
        .clk            (clk),
        .reset          (reset),
        .count_clear    (count_clear),
        .layer_step     (layer_step),
        .num_layers_cfg (num_layers_cfg),
        .layer_num      (layer_num),
        .last_layer     (last_layer)
    );

    layer_sequencer u_seq (
        .clk            (clk),
        .reset          (reset),
        .loading        (loading),
        .num_layers     (num_layers),
        .layer_computed (layer_computed),
        .drain_done     (drain_done),
        .last_layer     (last_layer),
        .need_weights   (need_weights),
        .accept_en      (accept_en),
        .layer_start    (layer_start),
        .drain_start    (drain_start),
        .layer_step     (layer_step),
        .count_clear    (count_clear),
        .num_layers_cfg (num_layers_cfg),
        .run_done       (run_done)
    );

endmodule

// ==== testbench/conv_engine_tb.sv ====
`timescale 1ns/10ps

module conv_engine_tb;

    localparam int NUM_RUNS   = 2;
    localparam int MAX_LAYERS = 4;
    localparam int MAX_STREAM = 24;
    localparam int VALID_PCT  = 75;
    localparam int READY_PCT  = 60;
    localparam int ZERO_PCT   = 40;

    // Cycle budget per layer with 4x margin on the random handshake rates
    localparam int LOAD_CYCLES   = conv_pkg::NUM_IN_CHANS * conv_pkg::NUM_OUT_MAPS + 4;
    localparam int STREAM_CYCLES = MAX_STREAM * 400 / VALID_PCT + 8;
    localparam int DRAIN_CYCLES  = conv_pkg::NUM_OUT_MAPS * 400 / READY_PCT + 8;
    localparam int WATCHDOG_NS   =
        (NUM_RUNS * MAX_LAYERS * (LOAD_CYCLES + STREAM_CYCLES + DRAIN_CYCLES) + 50) * 10;

    logic                           clk;
    logic                           reset;
    logic                           loading;
    logic [conv_pkg::LAYER_W-1:0]   num_layers;
    logic                           w_wr_en;
    logic [conv_pkg::CHAN_W-1:0]    w_chan;
    logic [conv_pkg::MAP_W-1:0]     w_map;
    logic [conv_pkg::WEIGHT_W-1:0]  w_data;
    logic                           in_valid;
    logic                           in_ready;
    logic [conv_pkg::ACT_W-1:0]     in_act;
    logic [conv_pkg::CHAN_W-1:0]    in_chan;
    logic                           in_last;
    logic                           out_valid;
    logic                           out_ready;
    logic [conv_pkg::ACC_W-1:0]     out_data;
    logic [conv_pkg::MAP_W-1:0]     out_map;
    logic [conv_pkg::LAYER_W-1:0]   out_layer;
    logic                           need_weights;
    logic                           run_done;
    logic [conv_pkg::COUNT_W-1:0]   skipped_count;

    // Reference model state
    logic signed [conv_pkg::WEIGHT_W-1:0] weight_model [conv_pkg::NUM_IN_CHANS]
                                                       [conv_pkg::NUM_OUT_MAPS];
    int acc_model [conv_pkg::NUM_OUT_MAPS];
    int skip_model;

    int seed;
    int error_count;
    int check_count;
    int run_done_count;

    conv_engine_top uut (
        .clk           (clk),
        .reset         (reset),
        .loading       (loading),
        .num_layers    (num_layers),
        .w_wr_en       (w_wr_en),
        .w_chan        (w_chan),
        .w_map         (w_map),
        .w_data        (w_data),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .in_act        (in_act),
        .in_chan       (in_chan),
        .in_last       (in_last),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_data      (out_data),
        .out_map       (out_map),
        .out_layer     (out_layer),
        .need_weights  (need_weights),
        .run_done      (run_done),
        .skipped_count (skipped_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run did not complete within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
    end

    always @(negedge clk) begin
        if (!reset && run_done) begin
            run_done_count++;
        end
    end

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s (got %0d, expected %0d)",
                     $time, what, actual, expected);
        end
    endtask

    function automatic bit chance(input int pct);
        int r;
        r = $unsigned($random(seed)) % 100;
        return r < pct;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + $unsigned($random(seed)) % (hi - lo + 1);
    endfunction

    task automatic check_idle();
        check_value(need_weights, 1, "need_weights while idle");
        check_value(in_ready, 0, "in_ready while idle");
        check_value(out_valid, 0, "out_valid while idle");
    endtask

    task automatic load_weights();
        for (int c = 0; c < conv_pkg::NUM_IN_CHANS; c++) begin
            for (int m = 0; m < conv_pkg::NUM_OUT_MAPS; m++) begin
                @(negedge clk);
                loading = 1'b1;
                w_wr_en = 1'b1;
                w_chan  = conv_pkg::CHAN_W'(c);
                w_map   = conv_pkg::MAP_W'(m);
                w_data  = conv_pkg::WEIGHT_W'($random(seed));
                weight_model[c][m] = w_data;
            end
        end
        @(negedge clk);
        w_wr_en = 1'b0;
        loading = 1'b0;
    endtask

    task automatic stream_layer(input bit zero_last);
        int                                length;
        int                                idx;
        bit                                sent;
        int                                a_int;
        int                                w_int;
        logic signed [conv_pkg::ACT_W-1:0] act_v;
        length     = rand_range(1, MAX_STREAM);
        idx        = 0;
        sent       = 1'b0;
        skip_model = 0;
        for (int m = 0; m < conv_pkg::NUM_OUT_MAPS; m++) begin
            acc_model[m] = 0;
        end
        while (idx < length) begin
            @(negedge clk);
            check_value(out_valid, 0, "out_valid during input stream");
            check_value(need_weights, 0, "need_weights during input stream");
            if (sent) begin
                in_valid = 1'b0;
                sent     = 1'b0;
            end
            if (!in_valid && chance(VALID_PCT)) begin
                in_last = (idx == length - 1);
                in_chan = conv_pkg::CHAN_W'(rand_range(0, conv_pkg::NUM_IN_CHANS - 1));
                if (chance(ZERO_PCT) || (in_last && zero_last)) begin
                    in_act = '0;
                end else begin
                    in_act = conv_pkg::ACT_W'($random(seed));
                    if (in_act == '0) begin
                        in_act = conv_pkg::ACT_W'(1);
                    end
                end
                in_valid = 1'b1;
            end
            // Transfer happens on the coming rising edge
            if (in_valid && in_ready) begin
                act_v = in_act;
                a_int = act_v;
                for (int m = 0; m < conv_pkg::NUM_OUT_MAPS; m++) begin
                    w_int = weight_model[in_chan][m];
                    acc_model[m] = acc_model[m] + a_int * w_int;
                end
                if (in_act == '0 && !in_last) begin
                    skip_model++;
                end
                idx++;
                sent = 1'b1;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        in_last  = 1'b0;
    endtask

    task automatic drain_layer(input int layer_idx, input bit final_layer);
        int                         map_idx;
        int                         expected;
        bit                         stalled;
        logic [conv_pkg::ACC_W-1:0] held_data;
        logic [conv_pkg::MAP_W-1:0] held_map;
        map_idx = 0;
        stalled = 1'b0;
        while (map_idx < conv_pkg::NUM_OUT_MAPS) begin
            @(negedge clk);
            if (stalled) begin
                check_value(out_valid, 1, "out_valid dropped while stalled");
                check_value(out_data, held_data, "out_data changed while stalled");
                check_value(out_map, held_map, "out_map changed while stalled");
            end
            out_ready = chance(READY_PCT);
            stalled   = 1'b0;
            if (out_valid && out_ready) begin
                expected = (acc_model[map_idx] < 0) ? 0 : acc_model[map_idx];
                check_value(out_map, map_idx, "out_map order");
                check_value(out_data, expected, "out_data after ReLU");
                check_value(out_layer, layer_idx, "out_layer");
                map_idx++;
            end else if (out_valid) begin
                held_data = out_data;
                held_map  = out_map;
                stalled   = 1'b1;
            end
        end
        @(negedge clk);
        out_ready = 1'b0;
        check_value(out_valid, 0, "out_valid after the last map");
        check_value(skipped_count, skip_model, "skipped_count at end of layer");
        check_value(run_done, final_layer, "run_done after the drain");
        check_value(need_weights, 1, "need_weights after the drain");
    endtask

    task automatic run_once(input int run_idx);
        int layers;
        layers = rand_range(1, MAX_LAYERS);
        @(negedge clk);
        num_layers = conv_pkg::LAYER_W'(layers);
        for (int l = 0; l < layers; l++) begin
            check_idle();
            load_weights();
            stream_layer(((run_idx + l) % 2) == 1);
            drain_layer(l, l == layers - 1);
        end
        @(negedge clk);
        check_value(run_done, 0, "run_done longer than one cycle");
        check_value(run_done_count, run_idx + 1, "run_done pulse count");
        check_value(need_weights, 1, "need_weights after the run");
    endtask

    initial begin
        seed           = 32'ha9a7_9b98;
        error_count    = 0;
        check_count    = 0;
        run_done_count = 0;
        reset          = 1'b1;
        loading        = 1'b0;
        num_layers     = '0;
        w_wr_en        = 1'b0;
        w_chan         = '0;
        w_map          = '0;
        w_data         = '0;
        in_valid       = 1'b0;
        in_act         = '0;
        in_chan        = '0;
        in_last        = 1'b0;
        out_ready      = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_idle();
        check_value(run_done, 0, "run_done after reset");
        check_value(skipped_count, 0, "skipped_count after reset");
        for (int r = 0; r < NUM_RUNS; r++) begin
            run_once(r);
        end
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
src/conv_pkg.sv
src/zero_skip_fetch.sv
src/weight_bank.sv
src/pointwise_mac.sv
src/relu_drain.sv
src/layer_counter.sv
src/layer_sequencer.sv
src/conv_engine_top.sv
testbench/conv_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run, and judge the result from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module conv_engine_tb -f verilog.f \
    -o conv_engine_sim \
    && ./obj_dir/conv_engine_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "CHECKS FAILED" sim.log && { echo "Simulation failed"; exit 1; } \
    || { echo "Simulation passed"; exit 0; }
